/* imdr_cfg.svh */
/*
 * imdr control configuration
 * counter, select and shift widths for the multiply/divide sequencer
 */
`ifndef IMDR_CFG_SVH
`define IMDR_CFG_SVH

// iteration counter, covers 31 divide steps
`define IMDR_CNT_W 5

// last divide/remainder step
`define IMDR_LAST {`IMDR_CNT_W{1'b1}}

// register-input selects for rac, ra, rb
`define IMDR_SEL_W 2

// b operand right shift in multiply post phase
`define IMDR_RSH_W 4

`endif

/* imdr_pkg.sv */
/*
 * imdr package
 * state encoding of the sequencer and a flag view of the state word
 */
`default_nettype none

package imdr_pkg;

  // one-hot-ish encoding, bit 0 idle, bit 1 add-back
  typedef enum logic [4:0] {
    IDLE      = 5'b00001,   // waiting for a request
    R_ADDBACK = 5'b00010,   // remainder final add-back
    L_SUB     = 5'b00100,   // div/rem shift left, subtract
    L_ADD     = 5'b01000,   // div/rem shift left, add
    R_ADD     = 5'b01100,   // booth shift right by 2, add
    D_POST    = 5'b10100,   // divide post complement
    M_POST    = 5'b11000,   // multiply post complement, align
    PRE_COMPL = 5'b11100    // compare, pre-complement, swap
  } imdr_state_e;

  typedef struct packed {
    logic [2:0] phase;      // numbers the six plain states
    logic       addback;    // only set in R_ADDBACK
    logic       idle;       // only set in IDLE
  } imdr_state_flags_t;

  // same 5 bits, read as a state or as flags
  typedef union packed {
    imdr_state_e       state;
    imdr_state_flags_t flags;
  } imdr_state_u;

endpackage

`default_nettype wire

/* imdr_fsm.sv */
/*
 * imdr state machine
 * sequences imul/idiv/irem through compare, loop and post phases,
 * counts iterations, tracks extreme operands and divide by zero
 */
`timescale 1ns/1ns
`default_nettype none
`include "imdr_cfg.svh"

module imdr_fsm (
  input  logic                   clk,
  input  logic                   reset_l,
  input  logic                   ie_mul_raw_d,   // imul request
  input  logic                   ie_div_raw_d,   // idiv request
  input  logic                   ie_rem_raw_d,   // irem request
  input  logic                   kill_inst_e,    // kills request in e stage
  input  logic                   pj_hold,        // pipeline hold
  input  logic                   bin_is0,        // zero divisor
  input  logic                   div_ovf,        // divide overflow
  input  logic                   sum_32,         // adder bit 32
  input  logic                   cout,           // adder carry out
  input  logic                   extreme_1,
  input  logic                   extreme_2,
  input  logic                   leading0_r,     // upper b bits all zero
  input  logic                   cur_rbb1,       // current rbb[1]
  output imdr_pkg::imdr_state_u  st,
  output imdr_pkg::imdr_state_u  nxt_st,
  output logic [`IMDR_CNT_W-1:0] cnt,
  output logic [`IMDR_CNT_W-1:0] nxt_cnt,
  output logic                   mul_e,
  output logic                   div_e,
  output logic                   rem_e,
  output logic                   nxt_mul_e,
  output logic                   nxt_div_e,
  output logic                   nxt_rem_e,
  output logic                   start,          // idle with live request
  output logic                   d_extreme,
  output logic                   r_extreme,
  output logic                   d_extreme_r,
  output logic                   r_extreme_r,
  output logic                   imdr_done_e,
  output logic                   imdr_div0_e
);
  import imdr_pkg::*;

  logic ie_mul_d, ie_div_d, ie_rem_d;
  logic any_req;
  logic loop_last;
  logic mul_exit;
  logic nxt_d_extreme_r, nxt_r_extreme_r;
  logic nxt_div0, div0_r;

  assign ie_mul_d = ie_mul_raw_d & ~kill_inst_e;   // killed requests vanish
  assign ie_div_d = ie_div_raw_d & ~kill_inst_e;
  assign ie_rem_d = ie_rem_raw_d & ~kill_inst_e;
  assign any_req  = ie_mul_d | ie_div_d | ie_rem_d;

  assign start     = (st.state == IDLE) && any_req;
  assign loop_last = (cnt == `IMDR_LAST);           // step 31
  assign mul_exit  = leading0_r && !cur_rbb1;       // nothing left to add

  // extreme div/rem operands found in the compare cycle
  assign d_extreme = (st.state == PRE_COMPL) && div_e && (div_ovf || bin_is0 || !sum_32);
  assign r_extreme = (st.state == PRE_COMPL) && rem_e && (div_ovf || bin_is0 || !sum_32);

  assign nxt_d_extreme_r = (st.state == PRE_COMPL) ? d_extreme :
                           (st.state != IDLE) && d_extreme_r;   // kept till idle
  assign nxt_r_extreme_r = (st.state == PRE_COMPL) ? r_extreme :
                           (st.state != IDLE) && r_extreme_r;

  assign nxt_div0 = (nxt_st.state != IDLE) && (div_e || rem_e) && bin_is0;

  always_comb begin
    nxt_st    = st;          // hold by default
    nxt_cnt   = cnt;
    nxt_mul_e = mul_e;
    nxt_div_e = div_e;
    nxt_rem_e = rem_e;
    case (st.state)
      IDLE: begin
        nxt_st.state = any_req ? PRE_COMPL : IDLE;
        nxt_mul_e    = ie_mul_d;   // latch the operation
        nxt_div_e    = ie_div_d;
        nxt_rem_e    = ie_rem_d;
      end
      PRE_COMPL: begin
        if (extreme_1 || extreme_2) begin
          nxt_st.state = M_POST;    // skip the loop
        end else begin
          nxt_st.state = mul_e ? R_ADD : L_SUB;
        end
        nxt_cnt = `IMDR_CNT_W'(1);
      end
      R_ADD: begin
        nxt_st.state = mul_exit ? M_POST : R_ADD;
        nxt_cnt      = mul_exit ? cnt : cnt + `IMDR_CNT_W'(1);
      end
      L_SUB, L_ADD: begin
        if (loop_last) begin
          nxt_st.state = div_e ? D_POST : R_ADDBACK;
        end else begin
          nxt_st.state = cout ? L_SUB : L_ADD;   // non-restoring step
        end
        nxt_cnt = cnt + `IMDR_CNT_W'(1);
      end
      M_POST, D_POST, R_ADDBACK: begin
        if (!pj_hold) nxt_st.state = IDLE;    // post state waits on hold
      end
      default: nxt_st.state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_l) begin
      st.state    <= IDLE;
      cnt         <= '0;
      mul_e       <= 1'b0;
      div_e       <= 1'b0;
      rem_e       <= 1'b0;
      d_extreme_r <= 1'b0;
      r_extreme_r <= 1'b0;
      div0_r      <= 1'b0;
    end else begin
      st          <= nxt_st;
      cnt         <= nxt_cnt;
      mul_e       <= nxt_mul_e;
      div_e       <= nxt_div_e;
      rem_e       <= nxt_rem_e;
      d_extreme_r <= nxt_d_extreme_r;
      r_extreme_r <= nxt_r_extreme_r;
      div0_r      <= nxt_div0;
    end
  end

  // done also while idle with no request pending
  assign imdr_done_e = (st.state == D_POST) || (st.state == M_POST) ||
                       (st.state == R_ADDBACK) ||
                       ((st.state == IDLE) && !(ie_mul_raw_d | ie_div_raw_d | ie_rem_raw_d));

  assign imdr_div0_e = div0_r & (ie_div_d | ie_rem_d);   // only with a live div/rem

endmodule

`default_nettype wire

/* imdr_path_sel.sv */
/*
 * imdr path select
 * decodes the sequencer state into datapath selects, clears, carry-in
 * and compare-cycle strobes; operand path selects are registered
 */
`timescale 1ns/1ns
`default_nettype none
`include "imdr_cfg.svh"

module imdr_path_sel (
  input  logic                   clk,
  input  logic                   reset_l,
  input  imdr_pkg::imdr_state_u  st,
  input  imdr_pkg::imdr_state_u  nxt_st,
  input  logic [`IMDR_CNT_W-1:0] cnt,
  input  logic [`IMDR_CNT_W-1:0] nxt_cnt,
  input  logic                   mul_e,
  input  logic                   div_e,
  input  logic                   rem_e,
  input  logic                   nxt_mul_e,
  input  logic                   nxt_div_e,
  input  logic                   nxt_rem_e,
  input  logic                   start,
  input  logic                   d_extreme,
  input  logic                   r_extreme,
  input  logic                   d_extreme_r,
  input  logic                   r_extreme_r,
  input  logic                   ie_data_a_d_31,   // a operand sign
  input  logic                   ie_data_b_d_31,   // b operand sign
  input  logic                   ain_is0,
  input  logic                   bin_is0,
  input  logic                   div_ovf,
  input  logic                   bin_sign,
  input  logic                   out_sign,
  input  logic                   out_sign_r,
  input  logic                   cout,
  input  logic                   rem_sum32,        // sum32 of a remainder
  input  logic                   nxt_booth_0,      // booth digit is zero
  input  logic                   booth_neg,        // booth digit negative
  output logic [`IMDR_SEL_W-1:0] sel_rac,
  output logic [`IMDR_SEL_W-1:0] sel_ra,
  output logic [`IMDR_SEL_W-1:0] sel_rb,
  output logic [`IMDR_RSH_W-1:0] sel_rsh_b,
  output logic                   clr_rac,
  output logic                   clr_ra2,
  output logic                   clr_rb,
  output logic                   clr_rbb,
  output logic                   clr_aop_n,        // active low
  output logic                   sel_rem_a,
  output logic                   sel_mag_a,
  output logic                   sel_rb_b,
  output logic                   sel_neg_b,
  output logic                   sel_sum_a,
  output logic                   sel_compl_a,
  output logic                   sel_sum,
  output logic                   cyc_compare,
  output logic                   ld_a_oprd0,
  output logic                   ld_b_oprd0,
  output logic                   ld_leading0,
  output logic                   clr_a_oprd0,
  output logic                   clr_b_oprd0,
  output logic                   clr_leading0,
  output logic                   ld_sign,
  output logic                   clr_sign,
  output logic                   cin,
  output logic                   mask32_n,         // active low
  output logic                   mul_cmp,
  output logic                   div_cmp,
  output logic                   rem_cmp
);
  import imdr_pkg::*;

  logic cmp_cyc, dr_e, last_step;
  logic nxt_clr_aop_n, nxt_rem_a, nxt_mag_a, nxt_rb_b, nxt_neg_b;
  logic nxt_sum_a, nxt_compl_a;
  logic [`IMDR_RSH_W-1:0] nxt_rsh_b;

  assign cmp_cyc   = (st.state == PRE_COMPL);
  assign dr_e      = div_e || rem_e;
  assign last_step = ((st.state == L_SUB) || (st.state == L_ADD)) && rem_e &&
                     (cnt == `IMDR_LAST);   // step before add-back

  // register-input selects, first match wins
  always_comb begin
    if ((cmp_cyc || nxt_st.flags.addback) && dr_e) sel_rac = `IMDR_SEL_W'(3);
    else if ((st.state != R_ADDBACK) && dr_e)      sel_rac = `IMDR_SEL_W'(2);
    else if ((st.state != M_POST) && mul_e)        sel_rac = `IMDR_SEL_W'(1);
    else                                           sel_rac = '0;

    if (start)                                           sel_ra = `IMDR_SEL_W'(3);
    else if (cmp_cyc && (mul_e || div_e || rem_sum32))   sel_ra = `IMDR_SEL_W'(2);
    else if (((st.state == L_SUB) || (st.state == L_ADD)) && dr_e)
                                                         sel_ra = `IMDR_SEL_W'(1);
    else                                                 sel_ra = '0;

    if (start)                                    sel_rb = `IMDR_SEL_W'(3);
    else if (cmp_cyc && (mul_e || dr_e))          sel_rb = `IMDR_SEL_W'(2);
    else if ((st.state != M_POST) && mul_e)       sel_rb = `IMDR_SEL_W'(1);
    else                                          sel_rb = '0;
  end

  // clears take effect next cycle, all forced in reset
  assign clr_rac = ~reset_l || (mul_e ? cmp_cyc : (st.state == IDLE));
  assign clr_ra2 = ~reset_l || cmp_cyc && (bin_is0 || rem_e && div_ovf);
  assign clr_rb  = ~reset_l || cmp_cyc && ain_is0 || last_step && cout;   // no add-back needed
  assign clr_rbb = ~reset_l;

  // a operand path
  assign nxt_clr_aop_n = !(nxt_booth_0 || (nxt_st.state == M_POST));
  assign nxt_rem_a     = nxt_div_e || nxt_rem_e;
  assign nxt_mag_a     = (nxt_st.state == PRE_COMPL);

  // b operand path, post phase aligns the product
  assign nxt_rsh_b = (nxt_st.state == M_POST) ? nxt_cnt[`IMDR_RSH_W-1:0] : '0;
  assign nxt_rb_b  = (nxt_st.state == PRE_COMPL) || nxt_div_e || nxt_rem_e ||
                     (nxt_st.state == M_POST) && nxt_cnt[`IMDR_CNT_W-1];
  assign nxt_neg_b = (nxt_st.state == PRE_COMPL) && !ie_data_b_d_31 ||
                     (nxt_st.state == M_POST) && out_sign && (nxt_mul_e || nxt_div_e) ||
                     (nxt_st.state == L_SUB);

  // final result path
  assign nxt_sum_a   = nxt_st.flags.addback;
  assign nxt_compl_a = (nxt_st.state == PRE_COMPL) ? ie_data_a_d_31 :
                       (nxt_div_e && !(d_extreme || d_extreme_r) ||
                        nxt_rem_e && !(r_extreme || r_extreme_r)) && out_sign;

  always_ff @(posedge clk) begin
    if (!reset_l) begin
      clr_aop_n   <= 1'b0;
      sel_rem_a   <= 1'b0;
      sel_mag_a   <= 1'b0;
      sel_rsh_b   <= '0;
      sel_rb_b    <= 1'b0;
      sel_neg_b   <= 1'b0;
      sel_sum_a   <= 1'b0;
      sel_compl_a <= 1'b0;
    end else begin
      clr_aop_n   <= nxt_clr_aop_n;
      sel_rem_a   <= nxt_rem_a;
      sel_mag_a   <= nxt_mag_a;
      sel_rsh_b   <= nxt_rsh_b;
      sel_rb_b    <= nxt_rb_b;
      sel_neg_b   <= nxt_neg_b;
      sel_sum_a   <= nxt_sum_a;
      sel_compl_a <= nxt_compl_a;
    end
  end

  assign sel_sum = mul_e || rem_e && (st.state != R_ADDBACK) && !r_extreme_r;

  // compare cycle and zero detect strobes
  assign cyc_compare  = cmp_cyc;
  assign ld_a_oprd0   = cmp_cyc;
  assign ld_b_oprd0   = cmp_cyc;
  assign ld_leading0  = cmp_cyc || mul_e;
  assign clr_a_oprd0  = ~reset_l || (st.state == IDLE);
  assign clr_b_oprd0  = ~reset_l || (st.state == IDLE);
  assign clr_leading0 = ~reset_l || (st.state == IDLE);

  assign ld_sign  = ~reset_l || cmp_cyc;
  assign clr_sign = ~reset_l || ain_is0 || bin_is0;
  assign mul_cmp  = cmp_cyc && mul_e;
  assign div_cmp  = cmp_cyc && div_e;
  assign rem_cmp  = cmp_cyc && rem_e;

  assign cin = cmp_cyc && !bin_sign ||              // negate b early
               (st.state == R_ADD) && booth_neg ||
               (st.state == M_POST) && out_sign_r ||
               (st.state == L_SUB);
  assign mask32_n = !((st.state == M_POST) || cmp_cyc);

endmodule

`default_nettype wire

/* imdr_ctrl.sv */
/*
 * imdr control top
 * iterative multiply/divide/remainder sequencer, fsm plus path select
 */
`timescale 1ns/1ns
`default_nettype none
`include "imdr_cfg.svh"

module imdr_ctrl (
  input  logic                   clk,
  input  logic                   reset_l,
  input  logic                   ie_mul_raw_d,
  input  logic                   ie_div_raw_d,
  input  logic                   ie_rem_raw_d,
  input  logic                   kill_inst_e,
  input  logic                   pj_hold,
  input  logic                   ie_data_a_d_31,
  input  logic                   ie_data_b_d_31,
  input  logic                   ain_is0,
  input  logic                   bin_is0,
  input  logic                   div_ovf,
  input  logic                   leading0_r,
  input  logic                   bin_sign,
  input  logic                   out_sign,
  input  logic                   out_sign_r,
  input  logic                   sum_32,
  input  logic                   cout,
  input  logic                   extreme_1,
  input  logic                   extreme_2,
  input  logic                   rem_sum32,
  input  logic                   nxt_booth_0,
  input  logic                   booth_neg,
  input  logic                   cur_rbb1,
  output logic                   imdr_done_e,
  output logic                   imdr_div0_e,
  output logic [`IMDR_SEL_W-1:0] sel_rac,
  output logic [`IMDR_SEL_W-1:0] sel_ra,
  output logic [`IMDR_SEL_W-1:0] sel_rb,
  output logic [`IMDR_RSH_W-1:0] sel_rsh_b,
  output logic                   clr_rac,
  output logic                   clr_ra2,
  output logic                   clr_rb,
  output logic                   clr_rbb,
  output logic                   clr_aop_n,
  output logic                   sel_rem_a,
  output logic                   sel_mag_a,
  output logic                   sel_rb_b,
  output logic                   sel_neg_b,
  output logic                   sel_sum_a,
  output logic                   sel_compl_a,
  output logic                   sel_sum,
  output logic                   cyc_compare,
  output logic                   ld_a_oprd0,
  output logic                   ld_b_oprd0,
  output logic                   ld_leading0,
  output logic                   clr_a_oprd0,
  output logic                   clr_b_oprd0,
  output logic                   clr_leading0,
  output logic                   ld_sign,
  output logic                   clr_sign,
  output logic                   cin,
  output logic                   mask32_n,
  output logic                   mul_cmp,
  output logic                   div_cmp,
  output logic                   rem_cmp
);
  import imdr_pkg::*;

  imdr_state_u            st, nxt_st;        // state, seen as state or flags
  logic [`IMDR_CNT_W-1:0] cnt, nxt_cnt;      // iteration count
  logic                   mul_e, div_e, rem_e;
  logic                   nxt_mul_e, nxt_div_e, nxt_rem_e;
  logic                   start;
  logic                   d_extreme, r_extreme;
  logic                   d_extreme_r, r_extreme_r;

  // sequencing, counter, done
  imdr_fsm u_fsm (.*);

  // datapath strobes from state
  imdr_path_sel u_path_sel (.*);

endmodule

`default_nettype wire

/* imdr_ctrl_sva.sv */
/*
 * imdr control assertions
 * reset values, done timing and add-back select on the top level
 */
`timescale 1ns/1ns
`default_nettype none
`include "imdr_cfg.svh"

module imdr_ctrl_sva (
  input logic                   clk, reset_l, kill_inst_e, imdr_done_e,
  input logic                   ie_mul_raw_d, ie_div_raw_d, ie_rem_raw_d,
  input imdr_pkg::imdr_state_u  st,
  input logic                   clr_rac, clr_ra2, clr_rb, clr_rbb, ld_sign,
  input logic                   clr_a_oprd0, clr_b_oprd0, clr_leading0,
  input logic                   clr_aop_n, sel_rem_a, sel_mag_a, sel_rb_b,
  input logic                   sel_neg_b, sel_sum_a, sel_compl_a,
  input logic [`IMDR_RSH_W-1:0] sel_rsh_b
);
  import imdr_pkg::*;

  int   fail_cnt = 0;   // failed assertions so far
  logic live_req;

  assign live_req = (ie_mul_raw_d | ie_div_raw_d | ie_rem_raw_d) & ~kill_inst_e;

  // clears forced in reset, registered selects low one cycle later
  a_reset_clr: assert property (@(posedge clk) !reset_l |-> clr_rac && clr_ra2 &&
      clr_rb && clr_rbb && clr_a_oprd0 && clr_b_oprd0 && clr_leading0 && ld_sign)
    else begin fail_cnt++; $error("clear strobes low during reset"); end

  a_reset_sel: assert property (@(posedge clk) !reset_l |=> !clr_aop_n && !sel_rem_a &&
      !sel_mag_a && !sel_rb_b && !sel_neg_b && !sel_sum_a && !sel_compl_a &&
      (sel_rsh_b == '0))
    else begin fail_cnt++; $error("registered selects not cleared by reset"); end

  a_no_done: assert property (@(posedge clk) disable iff (!reset_l)
      live_req |=> !$rose(imdr_done_e))
    else begin fail_cnt++; $error("done rose right after a request"); end

  a_sum_a: assert property (@(posedge clk) disable iff (!reset_l)
      sel_sum_a |-> (st.state == R_ADDBACK))
    else begin fail_cnt++; $error("sel_sum_a outside add-back"); end

endmodule

bind imdr_ctrl imdr_ctrl_sva u_sva (.*);

`default_nettype wire

/* tb_imdr_ctrl.sv */
/*
 * imdr control testbench
 * random mul/div/rem requests against a cycle model of the sequencer
 */
`timescale 1ns/1ns
`default_nettype none
`include "imdr_cfg.svh"

module tb_imdr_ctrl;
  import imdr_pkg::*;

  localparam int LOOP_STEPS = 31;   // div/rem iterations
  localparam int DIV_LAT    = 33;   // request cycle to post state
  localparam int EXT_LAT    = 2;    // request cycle to multiply post on extremes
  localparam int WAIT_MAX   = 400;
  localparam logic [1:0] OP_MUL = 2'd1, OP_DIV = 2'd2, OP_REM = 2'd3;

  logic clk, reset_l;
  logic ie_mul_raw_d, ie_div_raw_d, ie_rem_raw_d, kill_inst_e, pj_hold;
  logic ie_data_a_d_31, ie_data_b_d_31, ain_is0, bin_is0, div_ovf, leading0_r;
  logic bin_sign, out_sign, out_sign_r, sum_32, cout, extreme_1, extreme_2;
  logic rem_sum32, nxt_booth_0, booth_neg, cur_rbb1, imdr_done_e, imdr_div0_e;
  logic [`IMDR_SEL_W-1:0] sel_rac, sel_ra, sel_rb;
  logic [`IMDR_RSH_W-1:0] sel_rsh_b;
  logic clr_rac, clr_ra2, clr_rb, clr_rbb, clr_aop_n, sel_rem_a, sel_mag_a;
  logic sel_rb_b, sel_neg_b, sel_sum_a, sel_compl_a, sel_sum, cyc_compare;
  logic ld_a_oprd0, ld_b_oprd0, ld_leading0, clr_a_oprd0, clr_b_oprd0;
  logic clr_leading0, ld_sign, clr_sign, cin, mask32_n, mul_cmp, div_cmp, rem_cmp;

  logic [1:0]  req_op;               // staged request, 0 is none
  logic        kill_v, hold_v, ext2_v, bin0_v, done_s;
  imdr_state_e m_st;                 // model state of the coming cycle
  int          m_cnt;
  logic        m_mul, m_div, m_rem, m_div0;
  int          cyc, checks, errors, tests;

  imdr_ctrl dut (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic rand_bit();
    return 1'($urandom_range(1));
  endfunction

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    checks++;
    assert (exp === act) else begin
      $display("CHECK FAILED t=%0t %s exp=%0h act=%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // one clock: drive on the falling edge, check, advance the model
  task automatic step();
    imdr_state_e nx;
    logic live_m, live_d, live_r;
    logic cmp;
    @(negedge clk);
    cyc++;
    ie_mul_raw_d = (req_op == OP_MUL);
    ie_div_raw_d = (req_op == OP_DIV);
    ie_rem_raw_d = (req_op == OP_REM);
    kill_inst_e  = kill_v;
    pj_hold      = hold_v;
    extreme_2    = ext2_v;
    bin_is0      = bin0_v;
    cout         = rand_bit();
    booth_neg    = rand_bit();
    cur_rbb1     = rand_bit();
    leading0_r   = ($urandom_range(3) == 0);   // multiply ends now and then
    {ie_data_a_d_31, ie_data_b_d_31, ain_is0, div_ovf} = 4'($urandom_range(15));
    {bin_sign, out_sign, out_sign_r, sum_32} = 4'($urandom_range(15));
    {rem_sum32, nxt_booth_0} = 2'($urandom_range(3));
    #10;
    live_m = ie_mul_raw_d & ~kill_inst_e;
    live_d = ie_div_raw_d & ~kill_inst_e;
    live_r = ie_rem_raw_d & ~kill_inst_e;
    check_value("st", m_st, dut.st.state);
    check_value("imdr_done_e", (m_st == D_POST) || (m_st == M_POST) ||
                (m_st == R_ADDBACK) ||
                (m_st == IDLE) && !(ie_mul_raw_d | ie_div_raw_d | ie_rem_raw_d), imdr_done_e);
    check_value("imdr_div0_e", m_div0 & (live_d | live_r), imdr_div0_e);
    if (m_st == L_SUB) check_value("cin", 1'b1, cin);
    if (m_st == R_ADD) begin
      check_value("cin", booth_neg, cin);
      check_value("sel_rac", 2'd1, sel_rac);   // booth loop
      check_value("sel_rb", 2'd1, sel_rb);
    end
    if ((m_st == L_SUB || m_st == L_ADD) && m_rem && m_cnt == LOOP_STEPS && cout)
      check_value("clr_rb", 1'b1, clr_rb);   // remainder needs no add-back
    if (m_st == L_SUB || m_st == L_ADD) begin
      check_value("sel_ra", 2'd1, sel_ra);
      check_value("sel_rac", (m_rem && m_cnt == LOOP_STEPS) ? 2'd3 : 2'd2,
                  sel_rac);   // add-back coming
    end
    if (m_st == IDLE && (live_m | live_d | live_r)) begin
      check_value("sel_ra", 2'd3, sel_ra);   // operands load on start
      check_value("sel_rb", 2'd3, sel_rb);
    end
    if (m_st == R_ADDBACK) check_value("sel_sum", 1'b0, sel_sum);
    cmp = (m_st == PRE_COMPL);
    check_value("cyc_compare", cmp, cyc_compare);
    check_value("ld_a_oprd0", cmp, ld_a_oprd0);
    check_value("ld_b_oprd0", cmp, ld_b_oprd0);
    check_value("ld_leading0", cmp | m_mul, ld_leading0);
    check_value("mul_cmp", cmp & m_mul, mul_cmp);
    check_value("div_cmp", cmp & m_div, div_cmp);
    check_value("rem_cmp", cmp & m_rem, rem_cmp);
    check_value("mask32_n", !(cmp || m_st == M_POST), mask32_n);   // active low
    check_value("clr_sign", ain_is0 | bin_is0, clr_sign);   // zero operand drops sign
    done_s = imdr_done_e;
    case (m_st)
      IDLE:      nx = (live_m | live_d | live_r) ? PRE_COMPL : IDLE;
      PRE_COMPL: nx = (extreme_1 | extreme_2) ? M_POST : (m_mul ? R_ADD : L_SUB);
      R_ADD:     nx = (leading0_r && !cur_rbb1) ? M_POST : R_ADD;
      L_SUB, L_ADD: begin
        if (m_cnt == LOOP_STEPS) nx = m_div ? D_POST : R_ADDBACK;
        else nx = cout ? L_SUB : L_ADD;
      end
      default:   nx = pj_hold ? m_st : IDLE;   // post states wait on hold
    endcase
    m_div0 = (nx != IDLE) && (m_div || m_rem) && bin_is0;
    if (m_st == PRE_COMPL) m_cnt = 1;
    else if (m_st == L_SUB || m_st == L_ADD) m_cnt++;
    if (m_st == IDLE) {m_mul, m_div, m_rem} = {live_m, live_d, live_r};
    m_st = nx;
  endtask

  task automatic start_op(input logic [1:0] op, output int t0);
    int n;
    for (n = 0; n < WAIT_MAX && m_st != IDLE; n++) step();
    if (m_st != IDLE) begin
      $display("timeout: sequencer never returned to idle at %0t", $time);
      errors++;
    end
    req_op = op;
    step();        // request cycle T
    t0 = cyc;
    req_op = 2'd0;
  endtask

  task automatic wait_done(input int t0, output int lat);
    int n;
    lat = -1;
    for (n = 0; n < WAIT_MAX && lat < 0; n++) begin
      step();
      if (done_s) lat = cyc - t0;
    end
    if (lat < 0) begin
      $display("timeout: no done within %0d cycles at %0t", WAIT_MAX, $time);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int e0);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - e0);
  endtask

  initial begin
    int t0, lat, e0, k, n, extra;
    void'($urandom(34016));
    {clk, reset_l, ie_mul_raw_d, ie_div_raw_d, ie_rem_raw_d, kill_inst_e, pj_hold} = '0;
    {ie_data_a_d_31, ie_data_b_d_31, ain_is0, bin_is0, div_ovf, leading0_r} = '0;
    {bin_sign, out_sign, out_sign_r, sum_32, cout, extreme_1, extreme_2} = '0;
    {rem_sum32, nxt_booth_0, booth_neg, cur_rbb1} = '0;
    {req_op, kill_v, hold_v, ext2_v, bin0_v, done_s} = '0;
    {m_mul, m_div, m_rem, m_div0, m_cnt, cyc, checks, errors, tests} = '0;
    m_st = IDLE;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_l = 1'b1;

    e0 = errors;
    repeat (3) begin
      start_op(OP_DIV, t0);
      wait_done(t0, lat);
      check_value("divide latency", DIV_LAT, 16'(lat));
    end
    end_test("divide latency", e0);

    e0 = errors;
    repeat (3) begin
      start_op(OP_REM, t0);
      wait_done(t0, lat);
      check_value("remainder latency", DIV_LAT, 16'(lat));
    end
    end_test("remainder add-back", e0);

    e0 = errors;
    repeat (4) begin
      start_op(OP_MUL, t0);
      wait_done(t0, lat);
    end
    end_test("multiply loop", e0);

    // extreme operands skip to the multiply post phase
    e0 = errors;
    ext2_v = 1'b1;
    start_op(2'($urandom_range(3, 1)), t0);
    wait_done(t0, lat);
    check_value("extreme latency", EXT_LAT, 16'(lat));
    bin0_v = 1'b1;
    start_op(OP_DIV, t0);
    for (n = 0; n < WAIT_MAX && m_st != M_POST; n++) step();
    if (m_st != M_POST) begin
      $display("timeout: extreme divide never reached multiply post at %0t", $time);
      errors++;
    end
    req_op = OP_DIV;   // next divide shows up in the post cycle
    step();
    check_value("imdr_div0_e", 1'b1, imdr_div0_e);
    {req_op, bin0_v, ext2_v} = '0;
    end_test("extreme operands", e0);

    e0 = errors;
    k = $urandom_range(6, 1);
    hold_v = 1'b1;
    start_op(OP_DIV, t0);
    wait_done(t0, lat);
    req_op = OP_DIV;
    kill_v = 1'b1;     // killed request must not start
    extra = 0;
    repeat (k - 1) begin
      step();
      extra += done_s;
    end
    hold_v = 1'b0;
    step();
    extra += done_s;
    check_value("done hold cycles", 16'(k), 16'(extra));
    repeat (3) begin
      step();
      check_value("imdr_done_e", 1'b0, imdr_done_e);
    end
    {req_op, kill_v} = '0;
    step();
    check_value("imdr_done_e", 1'b1, imdr_done_e);
    end_test("hold and kill", e0);

    errors += dut.u_sva.fail_cnt;
    $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
imdr_pkg.sv
imdr_fsm.sv
imdr_path_sel.sv
imdr_ctrl.sv
imdr_ctrl_sva.sv
tb_imdr_ctrl.sv

/* Bender.yml */
package:
  name: imdr_ctrl

sources:
  - include_dirs:
      - .
    files:
      - imdr_pkg.sv
      - imdr_fsm.sv
      - imdr_path_sel.sv
      - imdr_ctrl.sv
  - target: test
    include_dirs:
      - .
    files:
      - imdr_ctrl_sva.sv
      - tb_imdr_ctrl.sv
